// File: Makefile
# Verilator build and run of the config space testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run tb_cfg_space"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_cfg_space -Mdir obj_dir -f cfg_space.f
	@out="$$(./obj_dir/Vtb_cfg_space)"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: cfg_space.f
hw/cfg_space_pkg.sv
hw/irq_msg_if.sv
hw/irq_cfg_if.sv
hw/cfg_regs.sv
hw/irq_msg_gen.sv
hw/irq_msg_fifo.sv
hw/irq_msg_out.sv
hw/cfg_space_top.sv
tests/tb_cfg_space.sv

// File: hw/cfg_regs.sv
`timescale 1ns/100ps

module cfg_regs import cfg_space_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cfg_sel_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic [2:0]  cs_bar_o,
  input  logic        irq_stat_i,
  irq_cfg_if.master   cfg
);

  logic                 cfg_cyc;    // strobe aimed at this function
  logic                 served_q;   // strobe already answered
  logic                 start;      // first clock of a config cycle
  logic                 wr_start;
  logic [REG_IDX_W-1:0] idx;        // dword index
  logic                 tbl_hit;
  logic [31:0]          bar_q [3];
  cmd_stat_u            cmd_q;
  cmd_stat_u            cmd_rd;     // as read back
  logic [31:0]          rd_val;

  // ==============================
  // decode and ack
  // ==============================
  assign cfg_cyc = cfg_sel_i && wb_cyc_i && wb_stb_i &&
                   wb_adr_i[29:22] == CFG_BUS &&
                   wb_adr_i[21:17] == CFG_DEVICE &&
                   wb_adr_i[16:14] == CFG_FUNC;
  assign start    = cfg_cyc && !served_q;
  assign wr_start = start && wb_we_i;
  assign idx      = wb_adr_i[REG_IDX_W+1:2];
  assign tbl_hit  = idx[REG_IDX_W-1:4] == REG_ID_IRQ_TBL[REG_IDX_W-1:4];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      served_q <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      served_q <= cfg_cyc;  // drops once the master releases stb
      wb_ack_o <= start;    // single clock, one after the strobe
    end
  end

  always_ff @(posedge clk_i) begin
    if (start)
      wb_dat_o <= rd_val;   // valid in the ack clock
  end

  // command word as seen by the bus, forced bits applied
  always_comb begin
    cmd_rd                  = cmd_q;
    cmd_rd.f.cmd.special_cyc = 1'b0;
    cmd_rd.f.cmd.mwi_en     = 1'b0;
    cmd_rd.f.cmd.vga_snoop  = 1'b0;
    cmd_rd.f.cmd.rsvd7      = 1'b0;
    cmd_rd.f.cmd.fast_b2b   = 1'b1;
    cmd_rd.f.cmd.rsvd_hi    = 5'd0;
    cmd_rd.f.stat           = 16'h02A0;  // medium devsel, fast b2b, 66 MHz
    cmd_rd.f.stat[3]        = irq_stat_i; // interrupt status
  end

  // ==============================
  // writes
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_q.raw <= {16'h0000, CMD_RESET};
      for (int b = 0; b < 3; b++) begin
        bar_q[b] <= BAR_RESET;
      end
    end else if (wr_start) begin
      if (idx == REG_ID_CMD_STAT) begin
        if (wb_sel_i[0]) cmd_q.raw[7:0] <= wb_dat_i[7:0];
        if (wb_sel_i[1]) cmd_q.raw[15:8] <= wb_dat_i[15:8];
      end
      for (int b = 0; b < 3; b++) begin
        if (idx == REG_ID_BAR0 + REG_IDX_W'(b)) begin
          if (&wb_sel_i && &wb_dat_i) begin
            bar_q[b] <= BAR_MASK;       // sizing probe
          end else begin
            for (int k = 0; k < 4; k++) begin
              if (wb_sel_i[k]) bar_q[b][8*k +: 8] <= wb_dat_i[8*k +: 8];
            end
          end
        end
      end
    end
  end

  // table port, slot and field straight from the index
  assign cfg.slot        = idx[SLOT_W+1:2];
  assign cfg.field       = idx[1:0];
  assign cfg.wdata       = wb_dat_i;
  assign cfg.wr_en       = wr_start && tbl_hit &&
                           (cfg.field == FLD_TID ? &wb_sel_i[1:0] : &wb_sel_i);
  assign cfg.sw_req      = wr_start && tbl_hit && cfg.field == FLD_TID && wb_sel_i[3];
  assign cfg.int_disable = cmd_rd.f.cmd.int_disable;

  // ==============================
  // read mux
  // ==============================
  always_comb begin
    case (idx)
      REG_ID_VENDOR:   rd_val = {CFG_DEVICE_ID, CFG_VENDOR_ID};
      REG_ID_CMD_STAT: rd_val = cmd_rd.raw;
      REG_ID_CLASS:    rd_val = {CFG_CLASS, CFG_SUBCLASS, CFG_PROGIF, CFG_REVISION};
      REG_ID_HEADER:   rd_val = {8'h00, CFG_HEADER_TYPE, 8'h00, CFG_CACHE_LINE};
      REG_ID_BAR0:     rd_val = bar_q[0];
      REG_ID_BAR1:     rd_val = bar_q[1];
      REG_ID_BAR2:     rd_val = bar_q[2];
      REG_ID_BAR3,
      REG_ID_BAR4,
      REG_ID_BAR5:     rd_val = 32'hFFFF_FFFF;
      REG_ID_SUBSYS:   rd_val = {CFG_SUBSYS_ID, CFG_SUBSYS_VENDOR_ID};
      REG_ID_ROM:      rd_val = CFG_ROM_ADDR;
      default:         rd_val = tbl_hit ? cfg.rdata : 32'd0;
    endcase
  end

  // chip selects, masked compare against each BAR
  always_comb begin
    for (int b = 0; b < 3; b++) begin
      cs_bar_o[b] = wb_cyc_i && ((wb_adr_i ^ bar_q[b]) & BAR_MASK) == 32'd0;
    end
  end

  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// File: hw/cfg_space_pkg.sv
package cfg_space_pkg;

  // ==============================
  // identity and bus match
  // ==============================
  localparam logic [7:0]  CFG_BUS              = 8'd0;
  localparam logic [4:0]  CFG_DEVICE           = 5'd3;
  localparam logic [2:0]  CFG_FUNC             = 3'd0;
  localparam logic [15:0] CFG_VENDOR_ID        = 16'h1A2B;
  localparam logic [15:0] CFG_DEVICE_ID        = 16'h0C31;
  localparam logic [15:0] CFG_SUBSYS_VENDOR_ID = 16'h1A2B;
  localparam logic [15:0] CFG_SUBSYS_ID        = 16'h0001;
  localparam logic [7:0]  CFG_CLASS            = 8'h03;   // display controller
  localparam logic [7:0]  CFG_SUBCLASS         = 8'h80;   // other
  localparam logic [7:0]  CFG_PROGIF           = 8'h01;
  localparam logic [7:0]  CFG_REVISION         = 8'h00;
  localparam logic [7:0]  CFG_CACHE_LINE       = 8'd8;    // in dwords
  localparam logic [7:0]  CFG_HEADER_TYPE      = 8'h00;   // plain device
  localparam logic [31:0] CFG_ROM_ADDR         = 32'hFFFF_FFF0;
  localparam logic [31:0] BAR_RESET            = 32'h0010_0000;
  localparam logic [31:0] BAR_MASK             = 32'hFFFF_F000;  // 4 KB window
  localparam logic [15:0] CMD_RESET            = 16'h0003;  // io + mem enabled

  // ==============================
  // register map, dword indices
  // ==============================
  localparam int REG_IDX_W = 6;
  localparam logic [REG_IDX_W-1:0] REG_ID_VENDOR   = 6'd0;
  localparam logic [REG_IDX_W-1:0] REG_ID_CMD_STAT = 6'd1;
  localparam logic [REG_IDX_W-1:0] REG_ID_CLASS    = 6'd2;
  localparam logic [REG_IDX_W-1:0] REG_ID_HEADER   = 6'd3;
  localparam logic [REG_IDX_W-1:0] REG_ID_BAR0     = 6'd4;
  localparam logic [REG_IDX_W-1:0] REG_ID_BAR1     = 6'd5;
  localparam logic [REG_IDX_W-1:0] REG_ID_BAR2     = 6'd6;
  localparam logic [REG_IDX_W-1:0] REG_ID_BAR3     = 6'd7;  // not implemented
  localparam logic [REG_IDX_W-1:0] REG_ID_BAR4     = 6'd8;
  localparam logic [REG_IDX_W-1:0] REG_ID_BAR5     = 6'd9;
  localparam logic [REG_IDX_W-1:0] REG_ID_SUBSYS   = 6'd11;
  localparam logic [REG_IDX_W-1:0] REG_ID_ROM      = 6'd12;
  localparam logic [REG_IDX_W-1:0] REG_ID_IRQ_TBL  = 6'd16;  // 4 dwords per slot

  // interrupt table fields
  localparam logic [1:0] FLD_DAT = 2'd0;
  localparam logic [1:0] FLD_ADR = 2'd1;
  localparam logic [1:0] FLD_TID = 2'd2;

  // ==============================
  // interrupt messages
  // ==============================
  localparam int IRQ_SLOTS      = 4;
  localparam int SLOT_W         = 2;
  localparam int TID_W          = 13;
  localparam int IRQ_HOLDOFF    = 63;   // also the timer saturation value
  localparam int MSG_FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W     = $clog2(MSG_FIFO_DEPTH);

  typedef struct packed {
    logic [4:0] rsvd_hi;      // 15:11 read 0
    logic       int_disable;
    logic       fast_b2b;     // reads 1
    logic       serr_en;
    logic       rsvd7;
    logic       parity_resp;
    logic       vga_snoop;    // 5:3 read 0
    logic       mwi_en;
    logic       special_cyc;
    logic       bus_master;
    logic       mem_space;
    logic       io_space;
  } cmd_bits_s;

  typedef struct packed {
    logic [15:0] stat;
    cmd_bits_s   cmd;
  } cmd_stat_s;

  typedef union packed {
    logic [31:0] raw;         // byte-enabled writes
    cmd_stat_s   f;           // decode and forcing
  } cmd_stat_u;

endpackage

// File: hw/cfg_space_top.sv
`timescale 1ns/100ps

module cfg_space_top import cfg_space_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // config port, wishbone classic
  input  logic                 cfg_sel_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [3:0]           wb_sel_i,
  input  logic [31:0]          wb_adr_i,
  input  logic [31:0]          wb_dat_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  output logic [2:0]           cs_bar_o,
  // interrupt levels and message port
  input  logic [IRQ_SLOTS-1:0] irq_i,
  output logic                 msg_valid_o,
  output logic [TID_W-1:0]     msg_tid_o,
  output logic [31:0]          msg_adr_o,
  output logic [31:0]          msg_dat_o,
  input  logic                 msg_ready_i
);

  logic cfg_busy;   // config cycle holds off message loads
  logic irq_stat;   // any level interrupt raised

  assign cfg_busy = cfg_sel_i && wb_cyc_i && wb_stb_i &&
                    wb_adr_i[29:22] == CFG_BUS &&
                    wb_adr_i[21:17] == CFG_DEVICE &&
                    wb_adr_i[16:14] == CFG_FUNC;
  assign irq_stat = |irq_i;

  irq_cfg_if cfg_tbl ();
  irq_msg_if gen_msg ();   // generator to fifo
  irq_msg_if out_msg ();   // fifo to output stage

  cfg_regs u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_sel_i  (cfg_sel_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_sel_i   (wb_sel_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .cs_bar_o   (cs_bar_o),
    .irq_stat_i (irq_stat),
    .cfg        (cfg_tbl.master)
  );

  irq_msg_gen u_gen (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .irq_i (irq_i),
    .cfg   (cfg_tbl.gen),
    .msg   (gen_msg.src)
  );

  irq_msg_fifo u_fifo (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .wr    (gen_msg.snk),
    .rd    (out_msg.src)
  );

  irq_msg_out u_out (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_busy_i  (cfg_busy),
    .fifo        (out_msg.snk),
    .msg_valid_o (msg_valid_o),
    .msg_tid_o   (msg_tid_o),
    .msg_adr_o   (msg_adr_o),
    .msg_dat_o   (msg_dat_o),
    .msg_ready_i (msg_ready_i)
  );

endmodule

// File: hw/irq_cfg_if.sv
`timescale 1ns/100ps

interface irq_cfg_if import cfg_space_pkg::*; ();

  logic              wr_en;        // table write strobe
  logic [SLOT_W-1:0] slot;
  logic [1:0]        field;        // dat, adr or tid
  logic [31:0]       wdata;
  logic              sw_req;       // software request for slot
  logic [31:0]       rdata;        // combinational table read
  logic              int_disable;  // from command word

  modport master (
    output wr_en, slot, field, wdata, sw_req, int_disable,
    input  rdata
  );

  modport gen (
    input  wr_en, slot, field, wdata, sw_req, int_disable,
    output rdata
  );

endinterface

// File: hw/irq_msg_fifo.sv
`timescale 1ns/100ps

module irq_msg_fifo import cfg_space_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  irq_msg_if.snk wr,
  irq_msg_if.src rd
);

  logic [TID_W+63:0]     mem [MSG_FIFO_DEPTH];  // {tid, adr, dat}
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  push;
  logic                  pop;

  assign wr.ready = count_q != MSG_FIFO_DEPTH[FIFO_PTR_W:0];  // not full
  assign rd.valid = count_q != '0;                           // not empty
  assign push     = wr.valid && wr.ready;
  assign pop      = rd.valid && rd.ready;

  // fall-through read, head entry always on the port
  assign {rd.tid, rd.adr, rd.dat} = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push)
      mem[wr_ptr_q] <= {wr.tid, wr.adr, wr.dat};
  end

  // ==============================
  // pointers and count
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(1);  // wraps at depth
      if (pop) rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(1);
      case ({push, pop})
        2'b10:   count_q <= count_q + (FIFO_PTR_W+1)'(1);
        2'b01:   count_q <= count_q - (FIFO_PTR_W+1)'(1);
        default: ;  // both or neither
      endcase
    end
  end

  a_count_range: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= MSG_FIFO_DEPTH[FIFO_PTR_W:0]);

endmodule

// File: hw/irq_msg_gen.sv
`timescale 1ns/100ps

module irq_msg_gen import cfg_space_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [IRQ_SLOTS-1:0] irq_i,
  irq_cfg_if.gen               cfg,
  irq_msg_if.src               msg
);

  logic [31:0]          tbl_dat [IRQ_SLOTS];
  logic [31:0]          tbl_adr [IRQ_SLOTS];
  logic [TID_W-1:0]     tbl_tid [IRQ_SLOTS];
  logic [5:0]           timer_q [IRQ_SLOTS];  // holdoff, saturates
  logic [IRQ_SLOTS-1:0] flag_q;               // pending per slot
  logic [IRQ_SLOTS-1:0] sat;
  logic [IRQ_SLOTS-1:0] cond;
  logic [IRQ_SLOTS-1:0] pend;                 // flags left after this transfer
  logic                 vld_q;
  logic [SLOT_W-1:0]    slot_q;               // slot on offer
  logic [SLOT_W-1:0]    pick;
  logic                 xfer;

  // table access from the register file
  always_comb begin
    case (cfg.field)
      FLD_DAT: cfg.rdata = tbl_dat[cfg.slot];
      FLD_ADR: cfg.rdata = tbl_adr[cfg.slot];
      FLD_TID: cfg.rdata = {{(32-TID_W){1'b0}}, tbl_tid[cfg.slot]};
      default: cfg.rdata = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (cfg.wr_en) begin
      case (cfg.field)
        FLD_DAT: tbl_dat[cfg.slot] <= cfg.wdata;
        FLD_ADR: tbl_adr[cfg.slot] <= cfg.wdata;
        FLD_TID: tbl_tid[cfg.slot] <= cfg.wdata[TID_W-1:0];
        default: ;
      endcase
    end
  end

  // ==============================
  // trigger and priority
  // ==============================
  assign xfer = vld_q && msg.ready;

  always_comb begin
    for (int s = 0; s < IRQ_SLOTS; s++) begin
      sat[s]  = timer_q[s] == IRQ_HOLDOFF[5:0];
      cond[s] = (irq_i[s] && !cfg.int_disable) ||
                (cfg.sw_req && cfg.slot == SLOT_W'(s));
    end
    pend = flag_q;
    if (xfer) pend[slot_q] = 1'b0;
    pick = '0;
    for (int s = IRQ_SLOTS-1; s >= 0; s--) begin
      if (pend[s]) pick = SLOT_W'(s);       // lowest index wins
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      flag_q <= '0;
      vld_q  <= 1'b0;
      for (int s = 0; s < IRQ_SLOTS; s++) begin
        timer_q[s] <= IRQ_HOLDOFF[5:0];
      end
    end else begin
      for (int s = 0; s < IRQ_SLOTS; s++) begin
        if (!sat[s]) timer_q[s] <= timer_q[s] + 6'd1;
        if (cond[s] && sat[s]) flag_q[s] <= 1'b1;
      end
      if (xfer) begin
        flag_q[slot_q]  <= 1'b0;  // clear wins over a new set
        timer_q[slot_q] <= 6'd0;  // holdoff restarts
      end
      if (!vld_q || xfer) vld_q <= |pend;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!vld_q || xfer)
      slot_q <= pick;
  end

  assign msg.valid = vld_q;
  assign msg.tid   = tbl_tid[slot_q];
  assign msg.adr   = tbl_adr[slot_q];
  assign msg.dat   = tbl_dat[slot_q];

  a_offer_sat: assert property (@(posedge clk_i) disable iff (rst_i)
    msg.valid |-> sat[slot_q]);

endmodule

// File: hw/irq_msg_if.sv
`timescale 1ns/100ps

interface irq_msg_if import cfg_space_pkg::*; ();

  logic             valid;  // held until taken
  logic             ready;
  logic [TID_W-1:0] tid;
  logic [31:0]      adr;
  logic [31:0]      dat;

  modport src (
    output valid, tid, adr, dat,
    input  ready
  );

  modport snk (
    input  valid, tid, adr, dat,
    output ready
  );

endinterface

// File: hw/irq_msg_out.sv
`timescale 1ns/100ps

module irq_msg_out import cfg_space_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             cfg_busy_i,
  irq_msg_if.snk           fifo,
  output logic             msg_valid_o,
  output logic [TID_W-1:0] msg_tid_o,
  output logic [31:0]      msg_adr_o,
  output logic [31:0]      msg_dat_o,
  input  logic             msg_ready_i
);

  logic load;   // register free and the bus quiet

  assign load       = (!msg_valid_o || msg_ready_i) && !cfg_busy_i;
  assign fifo.ready = load;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      msg_valid_o <= 1'b0;
    else if (load)
      msg_valid_o <= fifo.valid;
    else if (msg_ready_i)
      msg_valid_o <= 1'b0;   // taken while config traffic blocks the refill
  end

  always_ff @(posedge clk_i) begin
    if (load && fifo.valid) begin
      msg_tid_o <= fifo.tid;
      msg_adr_o <= fifo.adr;
      msg_dat_o <= fifo.dat;
    end
  end

  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    msg_valid_o && !msg_ready_i |=> msg_valid_o && $stable(msg_tid_o) &&
    $stable(msg_adr_o) && $stable(msg_dat_o));

endmodule

// File: tests/tb_cfg_space.sv
`timescale 1ns/100ps

module tb_cfg_space import cfg_space_pkg::*; ();

  localparam int MSG_W      = TID_W + 64;  // {tid, adr, dat}
  localparam int MAX_CYCLES = 4000;        // full run needs about 900 cycles

  logic                 clk_i;
  logic                 rst_i;
  logic                 cfg_sel_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [3:0]           wb_sel_i;
  logic [31:0]          wb_adr_i;
  logic [31:0]          wb_dat_i;
  logic [31:0]          wb_dat_o;
  logic                 wb_ack_o;
  logic [2:0]           cs_bar_o;
  logic [IRQ_SLOTS-1:0] irq_i;
  logic                 msg_valid_o;
  logic [TID_W-1:0]     msg_tid_o;
  logic [31:0]          msg_adr_o;
  logic [31:0]          msg_dat_o;
  logic                 msg_ready_i;

  // ==============================
  // model state
  // ==============================
  logic [15:0]      cmd_m;                 // command word as written
  logic [31:0]      bar_m [3];
  logic [31:0]      dat_m [IRQ_SLOTS];
  logic [31:0]      adr_m [IRQ_SLOTS];
  logic [TID_W-1:0] tid_m [IRQ_SLOTS];
  logic [MSG_W-1:0] exp_q [$];             // messages still to arrive, in order
  int               order [IRQ_SLOTS];
  int               seed       = 12581;
  int               cycles     = 0;
  int               level_slot = -1;       // slot of a held irq line, else -1
  int               lvl_count  = 0;
  int               lvl_last   = 0;

  cfg_space_top uut (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] cfg_adr(input logic [4:0] dev, input logic [5:0] idx);
    return {2'b00, CFG_BUS, dev, CFG_FUNC, 6'd0, idx, 2'b00};
  endfunction

  function automatic logic [5:0] tbl_idx(input int s, input logic [1:0] fld);
    return REG_ID_IRQ_TBL + 6'(4 * s) + {4'd0, fld};  // 4 dwords per slot
  endfunction

  function automatic logic [MSG_W-1:0] msg_of(input int s);
    return {tid_m[s], adr_m[s], dat_m[s]};
  endfunction

  // expected read value of one dword
  function automatic logic [31:0] ref_read(input logic [5:0] idx);
    logic [15:0] cmd;
    logic [15:0] stat;
    cmd  = (cmd_m & ~16'hF8B8) | 16'h0200;   // 15:11, 7, 5:3 read 0 and bit 9 reads 1
    stat = 16'h02A0 | {12'd0, |irq_i, 3'd0}; // bits 5, 7 and devsel 01, irq on bit 3
    case (idx)
      REG_ID_VENDOR:   return {CFG_DEVICE_ID, CFG_VENDOR_ID};
      REG_ID_CMD_STAT: return {stat, cmd};
      REG_ID_CLASS:    return {CFG_CLASS, CFG_SUBCLASS, CFG_PROGIF, CFG_REVISION};
      REG_ID_HEADER:   return {8'h00, CFG_HEADER_TYPE, 8'h00, CFG_CACHE_LINE};
      REG_ID_BAR0:     return bar_m[0];
      REG_ID_BAR1:     return bar_m[1];
      REG_ID_BAR2:     return bar_m[2];
      REG_ID_BAR3,
      REG_ID_BAR4,
      REG_ID_BAR5:     return 32'hFFFF_FFFF;  // unused BARs
      REG_ID_SUBSYS:   return {CFG_SUBSYS_ID, CFG_SUBSYS_VENDOR_ID};
      REG_ID_ROM:      return CFG_ROM_ADDR;
      default: begin
        if (idx >= REG_ID_IRQ_TBL && idx < 6'd32) begin
          case (idx[1:0])
            FLD_DAT: return dat_m[idx[3:2]];
            FLD_ADR: return adr_m[idx[3:2]];
            FLD_TID: return {{(32-TID_W){1'b0}}, tid_m[idx[3:2]]};
            default: return 32'd0;
          endcase
        end
        return 32'd0;
      end
    endcase
  endfunction

  task automatic compare(input string what, input logic [127:0] got,
                         input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s mismatch, got %0h expected %0h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // one config access, strobe kept for hold clocks after the ack
  task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] wdat, input int hold,
                           output logic [31:0] rdat);
    int lat;
    @(negedge clk_i);
    cfg_sel_i = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = we;
    wb_sel_i  = sel;
    wb_adr_i  = adr;
    wb_dat_i  = wdat;
    @(negedge clk_i);
    lat = 1;
    while (!wb_ack_o) begin  // cycle counter catches a lost ack
      @(negedge clk_i);
      lat++;
    end
    compare("ack latency", 128'(lat), 128'(1));
    rdat = wb_dat_o;
    repeat (hold) begin
      @(negedge clk_i);
      compare("ack while strobe held", 128'(wb_ack_o), 128'(0));
    end
    cfg_sel_i = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
  endtask

  task automatic reg_write(input logic [5:0] idx, input logic [3:0] sel, input logic [31:0] d);
    logic [31:0] unused;
    int          b;
    int          s;
    bus_cycle(1'b1, sel, cfg_adr(CFG_DEVICE, idx), d, 0, unused);
    if (idx == REG_ID_CMD_STAT) begin
      if (sel[0]) cmd_m[7:0] = d[7:0];
      if (sel[1]) cmd_m[15:8] = d[15:8];
    end else if (idx >= REG_ID_BAR0 && idx <= REG_ID_BAR2) begin
      b = int'(idx - REG_ID_BAR0);
      if (sel == 4'hF && d == 32'hFFFF_FFFF) begin
        bar_m[b] = BAR_MASK;  // sizing probe
      end else begin
        for (int k = 0; k < 4; k++) begin
          if (sel[k]) bar_m[b][8*k +: 8] = d[8*k +: 8];
        end
      end
    end else if (idx >= REG_ID_IRQ_TBL && idx < 6'd32) begin
      s = int'(idx[3:2]);
      if (idx[1:0] == FLD_DAT && sel == 4'hF) dat_m[s] = d;
      if (idx[1:0] == FLD_ADR && sel == 4'hF) adr_m[s] = d;
      if (idx[1:0] == FLD_TID && sel[1:0] == 2'b11) tid_m[s] = d[TID_W-1:0];
    end
  endtask

  task automatic read_check(input logic [5:0] idx);
    logic [31:0] rd;
    bus_cycle(1'b0, 4'hF, cfg_adr(CFG_DEVICE, idx), 32'd0, 0, rd);
    compare($sformatf("read of index %0d", idx), 128'(rd), 128'(ref_read(idx)));
  endtask

  // strobe that must never see an ack
  task automatic no_ack(input logic sel_fn, input logic [31:0] adr);
    @(negedge clk_i);
    cfg_sel_i = sel_fn;
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = 1'b0;
    wb_adr_i  = adr;
    repeat (6) begin
      @(negedge clk_i);
      compare("ack on foreign strobe", 128'(wb_ack_o), 128'(0));
    end
    cfg_sel_i = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
  endtask

  // chip selects expected for one address, given per probe
  task automatic probe_cs(input logic cyc, input logic [31:0] adr, input logic [2:0] exp);
    @(negedge clk_i);
    wb_cyc_i = cyc;
    wb_adr_i = adr;
    @(posedge clk_i);
    compare("cs_bar_o", 128'(cs_bar_o), 128'(exp));
  endtask

  // byte 3 alone fires the slot and leaves its tid untouched
  task automatic sw_request(input int s);
    exp_q.push_back(msg_of(s));
    reg_write(tbl_idx(s, FLD_TID), 4'b1000, 32'd0);
  endtask

  task automatic shuffle_slots();
    int j;
    int t;
    for (int i = 0; i < IRQ_SLOTS; i++) order[i] = i;
    for (int i = IRQ_SLOTS - 1; i > 0; i--) begin
      j        = $unsigned($random(seed)) % (i + 1);
      t        = order[i];
      order[i] = order[j];
      order[j] = t;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (8) @(negedge clk_i);  // room for a stray extra message
  endtask

  // ==============================
  // output monitor and watchdog
  // ==============================
  always @(posedge clk_i) begin : monitor
    logic [MSG_W-1:0] got;
    logic [MSG_W-1:0] exp;
    if (!rst_i && msg_valid_o && msg_ready_i) begin
      got = {msg_tid_o, msg_adr_o, msg_dat_o};
      if (level_slot >= 0) begin
        if (lvl_count > 0)
          compare("holdoff spacing", 128'((cycles - lvl_last) >= IRQ_HOLDOFF + 1), 128'(1));
        exp       = msg_of(level_slot);
        lvl_count = lvl_count + 1;
        lvl_last  = cycles;
        compare("level message", 128'(got), 128'(exp));
      end else if (exp_q.size() == 0) begin
        $display("unexpected message at %0t with tid %0h", $time, msg_tid_o);
        $display("Testbench failed");
        $fatal(1);
      end else begin
        exp = exp_q.pop_front();
        compare("message", 128'(got), 128'(exp));
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  // ==============================
  // stimulus
  // ==============================
  initial begin : stimulus
    logic [31:0]      rd;
    logic [MSG_W-1:0] held;
    rst_i       = 1'b1;
    cfg_sel_i   = 1'b0;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_sel_i    = 4'h0;
    wb_adr_i    = 32'd0;
    wb_dat_i    = 32'd0;
    irq_i       = '0;
    msg_ready_i = 1'b1;
    cmd_m       = CMD_RESET;
    for (int b = 0; b < 3; b++) bar_m[b] = BAR_RESET;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    // identity words, reset BARs, foreign strobes
    for (int i = 0; i < 16; i++) read_check(6'(i));
    bus_cycle(1'b0, 4'hF, cfg_adr(CFG_DEVICE, REG_ID_VENDOR), 32'd0, 3, rd);
    compare("held vendor read", 128'(rd), 128'(ref_read(REG_ID_VENDOR)));
    no_ack(1'b1, cfg_adr(CFG_DEVICE + 5'd1, REG_ID_VENDOR));  // other device
    no_ack(1'b0, cfg_adr(CFG_DEVICE, REG_ID_VENDOR));         // function not selected

    // command forcing and status irq bit, int_disable on meanwhile
    reg_write(REG_ID_CMD_STAT, 4'b0011, 32'hFFFF_FFFF);
    read_check(REG_ID_CMD_STAT);
    irq_i = 4'b0010;
    read_check(REG_ID_CMD_STAT);
    irq_i = '0;
    read_check(REG_ID_CMD_STAT);
    reg_write(REG_ID_CMD_STAT, 4'b0011, 32'h0000_0003);
    read_check(REG_ID_CMD_STAT);

    // BAR sizing, address write, partial write, chip selects
    reg_write(REG_ID_BAR0, 4'hF, 32'hFFFF_FFFF);
    reg_write(REG_ID_BAR1, 4'hF, 32'h4000_0000);
    reg_write(REG_ID_BAR2, 4'b0100, 32'h00AB_0000);
    for (int i = 4; i < 7; i++) read_check(6'(i));
    probe_cs(1'b1, 32'hFFFF_F123, 3'b001);  // inside the sized BAR0 window
    probe_cs(1'b1, 32'h4000_0ABC, 3'b010);
    probe_cs(1'b1, 32'h00AB_0FFC, 3'b100);  // top dword of BAR2
    probe_cs(1'b1, 32'h00AB_1000, 3'b000);  // first address past BAR2
    probe_cs(1'b1, 32'h1234_5678, 3'b000);
    probe_cs(1'b0, 32'h4000_0ABC, 3'b000);  // no cycle, no select

    // interrupt table contents
    for (int s = 0; s < IRQ_SLOTS; s++) begin
      reg_write(tbl_idx(s, FLD_DAT), 4'hF, 32'($random(seed)));
      reg_write(tbl_idx(s, FLD_ADR), 4'hF, 32'($random(seed)));
      reg_write(tbl_idx(s, FLD_TID), 4'b0011, 32'($random(seed)));
    end
    for (int i = 16; i < 32; i++) read_check(6'(i));

    // software requests in random slot order
    shuffle_slots();
    for (int i = 0; i < IRQ_SLOTS; i++) sw_request(order[i]);
    wait_drain();
    repeat (IRQ_HOLDOFF + 8) @(negedge clk_i);  // every timer back at saturation

    // three slots raised in one clock leave by index
    exp_q.push_back(msg_of(0));
    exp_q.push_back(msg_of(1));
    exp_q.push_back(msg_of(3));
    irq_i = 4'b1011;
    @(negedge clk_i);
    irq_i = '0;
    wait_drain();
    repeat (IRQ_HOLDOFF + 8) @(negedge clk_i);

    // held level on slot 2
    level_slot = 2;
    irq_i      = 4'b0100;
    repeat (220) @(negedge clk_i);
    irq_i = '0;
    repeat (IRQ_HOLDOFF + 16) @(negedge clk_i);
    level_slot = -1;
    compare("three or more held-level messages", 128'(lvl_count >= 3), 128'(1));

    // same level masked by int_disable, monitor rejects any message
    reg_write(REG_ID_CMD_STAT, 4'b0011, 32'h0000_0403);
    irq_i = 4'b0100;
    repeat (100) @(negedge clk_i);
    irq_i = '0;
    reg_write(REG_ID_CMD_STAT, 4'b0011, 32'h0000_0003);

    // back-pressure on the output port
    msg_ready_i = 1'b0;
    shuffle_slots();
    for (int i = 0; i < IRQ_SLOTS; i++) sw_request(order[i]);
    while (!msg_valid_o) @(negedge clk_i);
    held = {msg_tid_o, msg_adr_o, msg_dat_o};
    repeat (12) begin
      @(negedge clk_i);
      compare("valid under back-pressure", 128'(msg_valid_o), 128'(1));
      compare("held payload", 128'({msg_tid_o, msg_adr_o, msg_dat_o}), 128'(held));
    end
    msg_ready_i = 1'b1;
    wait_drain();

    $display("Testbench passed");
    $finish;
  end

endmodule
